// ==== project.f ====
+incdir+include
logic/play_pkg.sv
logic/play_if.sv
logic/play_ctrl.sv
logic/chart_mem.sv
logic/score_judge.sv
logic/note_output.sv
logic/play_top.sv
tb/tb_clock.sv
tb/play_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --timing --assert -Wno-fatal
TOP        = play_tb
RTL_TOP    = play_top
FILELIST   = project.f
LOG        = sim.log
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/play_tb.sv ====
`timescale 1ns/1ps
`include "play_config.svh"

module play_tb;
    logic prog_clk, rst, rst_req;
    logic [6:0] note_keys;
    logic oct_up, oct_down, chart_wr;
    logic [3:0] arrow_keys;
    play_pkg::user_id_t user_id;
    logic [`CHART_AW-1:0] chart_addr;
    play_pkg::note_t chart_note;
    logic [`CHART_AW:0] chart_len;
    play_pkg::play_state_t state;
    play_pkg::count_t countdown;
    play_pkg::note_t play_note;
    logic tone, save;
    logic [7:0] led;
    play_pkg::score_t score, save_score;
    play_pkg::user_id_t save_user;

    logic [31:0] seed = 32'h6747_3248;
    int n_checks = 0;
    int n_errors = 0;
    int n_saves = 0;
    play_pkg::note_t chart [12];

    tb_clock clk_i (.rst_req(rst_req), .prog_clk(prog_clk), .rst(rst));

    play_top dut_i (.*);

    // Count save pulses
    always @(negedge prog_clk) begin
        if (save) begin
            n_saves++;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Points for one scan by the timing-window rule
    function automatic int scan_points(play_pkg::note_t cur, play_pkg::note_t in_n,
                                       play_pkg::note_t h0, play_pkg::note_t h1,
                                       play_pkg::note_t h2);
        if (cur.keys == 7'd0) return 0;
        if (cur == in_n || cur == h0) return 10;
        if (cur == h1) return 8;
        if (cur == h2) return 5;
        return 0;
    endfunction

    function automatic logic [7:0] led_of(play_pkg::note_t n);
        logic [7:0] l;
        l = '0;
        if (n.keys != 7'd0) begin
            l[0] = (n.octave != 2'b00);
            for (int i = 0; i < 7; i++) l[7-i] = n.keys[i];
        end
        return l;
    endfunction

    // Low octave runs from 23 for C down to 17 for B
    // Each octave up is 7 cycles shorter
    function automatic int half_of(play_pkg::note_t n);
        int base;
        base = (n.octave == 2'b01) ? 23 : (n.octave == 2'b00) ? 16 : 9;
        for (int i = 0; i < 7; i++) if (n.keys[i]) return base - i;
        return 0;
    endfunction

    task automatic report(bit bad, string what, string got, string exp);
        n_checks++;
        if (bad) begin
            n_errors++;
            $display("Error at %0t ns: %s got %s expected %s", $time, what, got, exp);
        end
    endtask

    task automatic check_note(play_pkg::note_t got, play_pkg::note_t exp, string what);
        report(got !== exp, what, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_score(play_pkg::score_t got, play_pkg::score_t exp, string what);
        report(got !== exp, what, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_state(play_pkg::play_state_t got, play_pkg::play_state_t exp);
        report(got !== exp, "state", $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_digit(play_pkg::count_t got, play_pkg::count_t exp);
        report(got !== exp, "countdown", $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_user(play_pkg::user_id_t got, play_pkg::user_id_t exp);
        report(got !== exp, "save_user", $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_led(logic [7:0] got, logic [7:0] exp);
        report(got !== exp, "led", $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_tone(int got, int exp, string what);
        report(got != exp, what, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic apply_keys(play_pkg::note_t n);
        @(posedge prog_clk);
        note_keys <= n.keys;
        oct_up    <= (n.octave == 2'b10);
        oct_down  <= (n.octave == 2'b01);
    endtask

    // Counts negedges while tone stays at lvl
    task automatic measure_level(logic lvl, output int len);
        len = 0;
        while (tone == lvl && len < 60) begin
            @(negedge prog_clk);
            len++;
        end
        if (len >= 60) timeout_fail("a tone edge");
    endtask

    initial begin
        int t, total, pts, hi, lo;
        logic [31:0] r;
        play_pkg::note_t last, in_n, h [3];
        play_pkg::note_t rest_note;
        rest_note = '0;
        rst_req = 0;
        note_keys = '0;
        oct_up = 0;
        oct_down = 0;
        chart_wr = 0;
        arrow_keys = '0;
        user_id = 8'h5A;
        chart_addr = '0;
        chart_note = '0;
        chart_len = 7'd12;

        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            chart[i].octave = (r[15:8] % 3 == 0) ? 2'b00 : (r[15:8] % 3 == 1) ? 2'b01 : 2'b10;
            chart[i].keys = 7'd1 << (r[23:16] % 7);
            if (i == 2) chart[i].octave = 2'b10;
            if (i == 4 || i == 9) chart[i] = '0;
            else if (i > 0 && chart[i] == chart[i-1])
                chart[i].keys = {chart[i].keys[5:0], chart[i].keys[6]};
        end

        t = 0;
        while (rst && t < 20) begin
            @(negedge prog_clk);
            t++;
        end
        if (rst) timeout_fail("reset release");
        @(negedge prog_clk);
        check_state(state, play_pkg::COUNTDOWN);
        check_digit(countdown, 2'd3);
        check_score(score, 0, "score after reset");

        for (int i = 0; i < 12; i++) begin
            @(posedge prog_clk);
            chart_wr   <= 1'b1;
            chart_addr <= i[`CHART_AW-1:0];
            chart_note <= chart[i];
        end
        @(posedge prog_clk);
        chart_wr <= 1'b0;

        for (int d = 2; d >= 0; d--) begin
            t = 0;
            while (countdown == 2'(d + 1) && t < 200) begin
                @(negedge prog_clk);
                t++;
            end
            if (t >= 200) timeout_fail("countdown digit");
            check_digit(countdown, 2'(d));
        end
        t = 0;
        while (state != play_pkg::PLAYING && t < 200) begin
            @(negedge prog_clk);
            t++;
        end
        if (t >= 200) timeout_fail("PLAYING state");

        total = 0;
        last = '0;
        h[0] = '0;
        h[1] = '0;
        h[2] = '0;
        for (int k = 0; k < 12; k++) begin
            t = 0;
            while (play_note == last && t < 100) begin
                @(negedge prog_clk);
                t++;
            end
            if (t >= 100) timeout_fail("next chart note");
            check_note(play_note, chart[k], $sformatf("play_note slot %0d", k));
            last = play_note;
            r = next_rand();
            case (r[17:16] % 3)
                0: in_n = chart[k];
                1: in_n = (k == 0) ? rest_note : chart[k-1];
                default: begin
                    in_n = chart[k];
                    in_n.keys = (chart[k].keys == 0) ? 7'd1 :
                                {chart[k].keys[5:0], chart[k].keys[6]};
                end
            endcase
            apply_keys(in_n);
            @(negedge prog_clk);
            check_led(led, led_of(chart[k]));
            for (int s = 0; s < 2; s++) begin
                pts = scan_points(chart[k], in_n, h[0], h[1], h[2]);
                total += pts;
                h[2] = h[1];
                h[1] = h[0];
                h[0] = in_n;
            end
            if (k == 2) begin
                measure_level(1'b0, lo);
                measure_level(1'b1, hi);
                measure_level(1'b0, lo);
                check_tone(hi, half_of(chart[k]), "tone high time");
                check_tone(lo, half_of(chart[k]), "tone low time");
            end
            // Tone must stay low for the whole rest step
            if (chart[k].keys == 0) begin
                t = 0;
                while (play_note == chart[k] && t < 100) begin
                    report(tone !== 1'b0, "tone during rest", $sformatf("%b", tone), "0");
                    @(negedge prog_clk);
                    t++;
                end
                if (t >= 100) timeout_fail("end of rest step");
            end
        end

        t = 0;
        while (state != play_pkg::FINISHED && t < 100) begin
            @(negedge prog_clk);
            t++;
        end
        if (t >= 100) timeout_fail("FINISHED state");
        check_note(play_note, rest_note, "play_note after chart");
        check_score(score, total, "final score");

        n_saves = 0;
        @(posedge prog_clk);
        arrow_keys <= 4'b0001;
        t = 0;
        while (!save && t < 10) begin
            @(negedge prog_clk);
            t++;
        end
        if (!save) timeout_fail("save strobe");
        check_user(save_user, 8'h5A);
        check_score(save_score, total, "save_score");
        check_state(state, play_pkg::MENU);
        @(posedge prog_clk);
        arrow_keys <= 4'b0000;
        repeat (20) @(negedge prog_clk);
        report(n_saves != 1, "save pulse count", $sformatf("%0d", n_saves), "1");

        // Second run leaves through the exit key during the countdown
        @(posedge prog_clk);
        rst_req <= 1'b1;
        @(posedge prog_clk);
        rst_req <= 1'b0;
        t = 0;
        while (!rst && t < 10) begin
            @(negedge prog_clk);
            t++;
        end
        if (!rst) timeout_fail("second reset");
        t = 0;
        while (rst && t < 20) begin
            @(negedge prog_clk);
            t++;
        end
        if (rst) timeout_fail("second reset release");
        n_saves = 0;
        check_state(state, play_pkg::COUNTDOWN);
        @(posedge prog_clk);
        arrow_keys <= 4'b0010;
        t = 0;
        while (state != play_pkg::MENU && t < 10) begin
            @(negedge prog_clk);
            t++;
        end
        if (t >= 10) timeout_fail("MENU after exit");
        @(posedge prog_clk);
        arrow_keys <= 4'b0000;
        repeat (400) @(negedge prog_clk);
        check_state(state, play_pkg::MENU);
        check_score(score, 0, "score after exit");
        report(n_saves != 0, "save pulses after exit", $sformatf("%0d", n_saves), "0");

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    input  logic rst_req,
    output logic prog_clk,
    output logic rst
);
    initial prog_clk = 1'b0;
    always #10 prog_clk = ~prog_clk;

    // Reset for 4 cycles at start and again on request
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge prog_clk);
        rst <= 1'b0;
        forever begin
            @(posedge prog_clk);
            if (rst_req) begin
                rst <= 1'b1;
                repeat (4) @(posedge prog_clk);
                rst <= 1'b0;
            end
        end
    end
endmodule

// ==== logic/play_top.sv ====
`timescale 1ns/1ps
`include "play_config.svh"

module play_top (
    input  logic                  prog_clk,
    input  logic                  rst,
    input  logic [6:0]            note_keys,
    input  logic                  oct_up,
    input  logic                  oct_down,
    input  logic [3:0]            arrow_keys,
    input  play_pkg::user_id_t    user_id,
    input  logic                  chart_wr,
    input  logic [`CHART_AW-1:0]  chart_addr,
    input  play_pkg::note_t       chart_note,
    input  logic [`CHART_AW:0]    chart_len,
    output play_pkg::play_state_t state,
    output play_pkg::count_t      countdown,
    output play_pkg::note_t       play_note,
    output logic                  tone,
    output logic [7:0]            led,
    output play_pkg::score_t      score,
    output logic                  save,
    output play_pkg::user_id_t    save_user,
    output play_pkg::score_t      save_score
);
    play_if bus_i (.prog_clk(prog_clk));

    play_ctrl ctrl_i (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .bus        (bus_i.ctrl),
        .chart_len  (chart_len),
        .arrow_keys (arrow_keys),
        .user_id    (user_id),
        .score      (score),
        .state      (state),
        .countdown  (countdown),
        .save       (save),
        .save_user  (save_user),
        .save_score (save_score)
    );

    chart_mem mem_i (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .bus        (bus_i.mem),
        .chart_wr   (chart_wr),
        .chart_addr (chart_addr),
        .chart_note (chart_note)
    );

    score_judge judge_i (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .bus       (bus_i.judge),
        .note_keys (note_keys),
        .oct_up    (oct_up),
        .oct_down  (oct_down),
        .score     (score)
    );

    note_output voice_i (
        .prog_clk (prog_clk),
        .rst      (rst),
        .bus      (bus_i.voice),
        .tone     (tone),
        .led      (led)
    );

    assign play_note = bus_i.cur_note;

endmodule

// ==== logic/note_output.sv ====
`timescale 1ns/1ps
`include "play_config.svh"

module note_output (
    input  logic       prog_clk,
    input  logic       rst,
    play_if.voice      bus,
    output logic       tone,
    output logic [7:0] led
);
    play_pkg::note_t prev_note;
    logic [4:0]      half;
    logic [4:0]      cnt;
    logic [7:0]      led_dec;
    logic            is_rest;

    function automatic logic [4:0] half_period(input play_pkg::note_t n);
        case (n)
            9'b01_0000001: half_period = `TONE_C3;
            9'b01_0000010: half_period = `TONE_D3;
            9'b01_0000100: half_period = `TONE_E3;
            9'b01_0001000: half_period = `TONE_F3;
            9'b01_0010000: half_period = `TONE_G3;
            9'b01_0100000: half_period = `TONE_A3;
            9'b01_1000000: half_period = `TONE_B3;
            9'b00_0000001: half_period = `TONE_C4;
            9'b00_0000010: half_period = `TONE_D4;
            9'b00_0000100: half_period = `TONE_E4;
            9'b00_0001000: half_period = `TONE_F4;
            9'b00_0010000: half_period = `TONE_G4;
            9'b00_0100000: half_period = `TONE_A4;
            9'b00_1000000: half_period = `TONE_B4;
            9'b10_0000001: half_period = `TONE_C5;
            9'b10_0000010: half_period = `TONE_D5;
            9'b10_0000100: half_period = `TONE_E5;
            9'b10_0001000: half_period = `TONE_F5;
            9'b10_0010000: half_period = `TONE_G5;
            9'b10_0100000: half_period = `TONE_A5;
            9'b10_1000000: half_period = `TONE_B5;
            default:       half_period = 5'd0;
        endcase
    endfunction

    assign half    = half_period(bus.cur_note);
    assign is_rest = (bus.cur_note.keys == '0);

    // C lights led[7], B lights led[1]
    always_comb begin
        led_dec = '0;
        if (!is_rest) begin
            led_dec[0] = (bus.cur_note.octave != 2'b00);
            for (int i = 0; i < 7; i++) begin
                led_dec[7-i] = bus.cur_note.keys[i];
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            prev_note <= '0;
            cnt       <= '0;
            tone      <= 1'b0;
            led       <= '0;
        end else begin
            prev_note <= bus.cur_note;
            led       <= led_dec;
            if (bus.cur_note != prev_note || is_rest || half == '0) begin
                cnt  <= '0;
                tone <= 1'b0;
            end else if (cnt == half - 1'b1) begin
                cnt  <= '0;
                tone <= ~tone;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/score_judge.sv ====
`timescale 1ns/1ps

module score_judge (
    input  logic             prog_clk,
    input  logic             rst,
    play_if.judge            bus,
    input  logic [6:0]       note_keys,
    input  logic             oct_up,
    input  logic             oct_down,
    output play_pkg::score_t score
);
    play_pkg::note_t   in_note;
    play_pkg::note_t   hist [3];
    play_pkg::points_t points;
    logic [14:0]       sum;

    // Both octave keys together count as middle
    assign in_note.octave = {oct_up & ~oct_down, oct_down & ~oct_up};
    assign in_note.keys   = note_keys;

    // hist[0] is the previous scan, hist[2] three scans back
    always_comb begin
        points = '0;
        if (bus.cur_note.keys != '0) begin
            if (bus.cur_note == in_note || bus.cur_note == hist[0]) begin
                points = 4'd10;
            end else if (bus.cur_note == hist[1]) begin
                points = 4'd8;
            end else if (bus.cur_note == hist[2]) begin
                points = 4'd5;
            end
        end
    end

    assign sum = {1'b0, score} + {11'd0, points};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score   <= '0;
            hist[0] <= '0;
            hist[1] <= '0;
            hist[2] <= '0;
        end else if (bus.scan && bus.play_en) begin
            // Saturate at full scale
            score   <= sum[14] ? '1 : sum[13:0];
            hist[0] <= in_note;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
        end
    end

    a_score_mono: assert property (@(posedge prog_clk) disable iff (rst)
        score >= $past(score));

endmodule

// ==== logic/chart_mem.sv ====
`timescale 1ns/1ps
`include "play_config.svh"

module chart_mem (
    input  logic                 prog_clk,
    input  logic                 rst,
    play_if.mem                  bus,
    input  logic                 chart_wr,
    input  logic [`CHART_AW-1:0] chart_addr,
    input  play_pkg::note_t      chart_note
);
    play_pkg::note_t slots [`CHART_LEN];

    always_ff @(posedge prog_clk) begin
        if (chart_wr) begin
            slots[chart_addr] <= chart_note;
        end
    end

    // Rest wins over a fetch in the same cycle
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            bus.cur_note <= '0;
        end else if (bus.rest) begin
            bus.cur_note <= '0;
        end else if (bus.fetch) begin
            bus.cur_note <= slots[bus.note_idx];
        end
    end

    a_note_legal: assert property (@(posedge prog_clk) disable iff (rst)
        chart_wr |-> $onehot0(chart_note.keys) && chart_note.octave != 2'b11);

endmodule

// ==== logic/play_ctrl.sv ====
`timescale 1ns/1ps
`include "play_config.svh"

module play_ctrl (
    input  logic                  prog_clk,
    input  logic                  rst,
    play_if.ctrl                  bus,
    input  logic [`CHART_AW:0]    chart_len,
    input  logic [3:0]            arrow_keys,
    input  play_pkg::user_id_t    user_id,
    input  play_pkg::score_t      score,
    output play_pkg::play_state_t state,
    output play_pkg::count_t      countdown,
    output logic                  save,
    output play_pkg::user_id_t    save_user,
    output play_pkg::score_t      save_score
);
    localparam int STEP_W = $clog2(`STEP_DIV);
    localparam int DIG_W = (`COUNT_STEPS > 1) ? $clog2(`COUNT_STEPS) : 1;

    logic [STEP_W-1:0]  step_cnt;
    logic [DIG_W-1:0]   dig_cnt;
    logic [`CHART_AW:0] idx_cnt;
    logic               step;
    logic               dig_done;
    logic               save_key;
    logic               exit_key;
    logic               save_now;
    logic               go_play;
    logic               go_finish;
    logic               go_menu;

    assign step = (step_cnt == STEP_W'(`STEP_DIV - 1));
    assign bus.scan = (step_cnt == STEP_W'(`STEP_DIV / 4)) ||
                      (step_cnt == STEP_W'(3 * `STEP_DIV / 4));
    assign dig_done = step && (dig_cnt == DIG_W'(`COUNT_STEPS - 1));

    assign save_key = (arrow_keys == 4'b0001);
    assign exit_key = (arrow_keys == 4'b0010);
    assign save_now = (state == play_pkg::FINISHED) && save_key;

    assign go_menu   = (state != play_pkg::MENU) && (exit_key || save_now);
    assign go_play   = (state == play_pkg::COUNTDOWN) && dig_done && (countdown == '0);
    assign go_finish = (state == play_pkg::PLAYING) && step && (idx_cnt == chart_len);

    // Slot fetch on every step of play, the first one on the transition tick
    assign bus.fetch = !go_menu &&
                       (go_play || ((state == play_pkg::PLAYING) && step && !go_finish));
    assign bus.rest     = go_finish || go_menu;
    assign bus.note_idx = idx_cnt[`CHART_AW-1:0];
    assign bus.play_en  = (state == play_pkg::PLAYING);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Countdown digits, COUNT_STEPS steps each
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            dig_cnt   <= '0;
            countdown <= 2'd3;
        end else if (state == play_pkg::COUNTDOWN && step) begin
            if (dig_done) begin
                dig_cnt <= '0;
                if (countdown != '0) begin
                    countdown <= countdown - 1'b1;
                end
            end else begin
                dig_cnt <= dig_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            idx_cnt <= '0;
        end else if (bus.fetch) begin
            idx_cnt <= idx_cnt + 1'b1;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= play_pkg::COUNTDOWN;
        end else if (go_menu) begin
            state <= play_pkg::MENU;
        end else if (go_play) begin
            state <= play_pkg::PLAYING;
        end else if (go_finish) begin
            state <= play_pkg::FINISHED;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            save <= 1'b0;
        end else begin
            save <= save_now;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (save_now) begin
            save_user  <= user_id;
            save_score <= score;
        end
    end

    // Fetches land in PLAYING, the last one before the state moves on
    a_fetch_playing: assert property (@(posedge prog_clk) disable iff (rst)
        bus.fetch |=> state == play_pkg::PLAYING);

    a_save_single: assert property (@(posedge prog_clk) disable iff (rst)
        save |=> !save);

    a_len_nonzero: assert property (@(posedge prog_clk) disable iff (rst)
        $rose(bus.play_en) |-> chart_len != '0);

endmodule

// ==== logic/play_if.sv ====
`timescale 1ns/1ps
`include "play_config.svh"

interface play_if (
    input logic prog_clk
);
    logic                scan;
    logic                fetch;
    logic                rest;
    logic [`CHART_AW-1:0] note_idx;
    logic                play_en;
    play_pkg::note_t     cur_note;

    modport ctrl (input prog_clk, output scan, fetch, rest, note_idx, play_en);

    modport mem (input prog_clk, fetch, rest, note_idx, output cur_note);

    modport judge (input prog_clk, scan, play_en, cur_note);

    modport voice (input prog_clk, cur_note);

endinterface

// ==== logic/play_pkg.sv ====
package play_pkg;

    // Octave 00 middle, 01 low, 10 high
    // Keys one-hot C (bit 0) to B (bit 6), all zero is a rest
    typedef struct packed {
        logic [1:0] octave;
        logic [6:0] keys;
    } note_t;

    typedef logic [13:0] score_t;

    typedef enum logic [1:0] {
        COUNTDOWN = 2'd0,
        PLAYING   = 2'd1,
        FINISHED  = 2'd2,
        MENU      = 2'd3
    } play_state_t;

    typedef logic [1:0] count_t;

    typedef logic [7:0] user_id_t;

    // Points earned on a single scan
    typedef logic [3:0] points_t;

endpackage

// ==== include/play_config.svh ====
`ifndef PLAY_CONFIG_SVH
`define PLAY_CONFIG_SVH

`define CHART_LEN   64
`define CHART_AW    6
`define STEP_DIV    40
`define COUNT_STEPS 2

// Tone half-periods in prog_clk cycles, low octave is slowest
`define TONE_C3 5'd23
`define TONE_D3 5'd22
`define TONE_E3 5'd21
`define TONE_F3 5'd20
`define TONE_G3 5'd19
`define TONE_A3 5'd18
`define TONE_B3 5'd17
`define TONE_C4 5'd16
`define TONE_D4 5'd15
`define TONE_E4 5'd14
`define TONE_F4 5'd13
`define TONE_G4 5'd12
`define TONE_A4 5'd11
`define TONE_B4 5'd10
`define TONE_C5 5'd9
`define TONE_D5 5'd8
`define TONE_E5 5'd7
`define TONE_F5 5'd6
`define TONE_G5 5'd5
`define TONE_A5 5'd4
`define TONE_B5 5'd3

`endif
